//--- flist.f
src/mm_rx_pkg.sv
src/mm_octet_if.sv
src/mm_hdr_if.sv
src/rx_deserializer.sv
src/smd_decoder.sv
src/mcrc_checker.sv
src/rx_result_reporter.sv
src/mm_rx_top.sv
sim/mm_rx_tb.sv

//--- sim/mm_rx_tb.sv
//////////////////////////////
// MAC merge receive testbench
// LCG stimulus, mPacket builder, reference model
// compare process and watchdog
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_rx_tb import mm_rx_pkg::*;;

   typedef logic [7:0] octet_q_t [$];
   typedef struct packed
   {
      smd_kind_t  kind;
      logic [1:0] frame;
      logic [2:0] frag;
      logic       ok;
   } exp_t;

   logic        rTXByteSent = 1'b0;
   logic        reset_begin;
   logic        rx_bit;
   logic        rx_dv;
   logic        result_strobe;
   smd_kind_t   result_kind;
   logic [1:0]  result_frame_cnt;
   logic [2:0]  result_frag_cnt;
   logic        result_mcrc_ok;
   logic [31:0] rng_state = 32'h5af65e43;
   logic [1:0]  stim_q [$];  // {rx_dv, rx_bit} per clock, prepared before reset ends
   exp_t        exp_q [$];   // expected results in mPacket order
   bit          stim_ready = 1'b0;
   int          n_checked = 0;

   mm_rx_top i_dut (
      .rTXByteSent      (rTXByteSent),
      .reset_begin      (reset_begin),
      .rx_bit           (rx_bit),
      .rx_dv            (rx_dv),
      .result_strobe    (result_strobe),
      .result_kind      (result_kind),
      .result_frame_cnt (result_frame_cnt),
      .result_frag_cnt  (result_frag_cnt),
      .result_mcrc_ok   (result_mcrc_ok)
   );

   always #5 rTXByteSent = ~rTXByteSent;  // 10 ns period

   // linear congruential generator, uses the upper 24 bits only
   function automatic int rand_below(input int n);
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return int'(rng_state[31:8]) % n;
   endfunction

   // register starts at all ones, one serial step per bit with the lsb of each octet first
   function automatic logic [31:0] mcrc_word(input octet_q_t pkt, input int first,
                                             input int count);
      logic [31:0] r;
      logic [7:0]  d;
      logic        fb;
      r = MCRC_INIT;
      for (int i = first; i < first + count; i++)
      begin
         d = pkt[i];
         for (int b = 0; b < 8; b++)
         begin
            fb = d[b] ^ r[31];
            r  = {r[30:0], 1'b0} ^ (fb ? MCRC_POLY : 32'd0);
         end
      end
      return r ^ MCRC_XOR;  // low half inverted relative to the FCS
   endfunction

   // expected result for one mPacket, built from its full octets only
   function automatic exp_t expected_result(input octet_q_t pkt);
      exp_t        r;
      int          pre;
      int          pos;    // index of the delimiter, -1 when none was found
      int          after;  // octets that follow the delimiter
      int          n;
      logic [7:0]  d;
      r.kind  = SMD_NONE;
      r.frame = 2'd0;
      r.frag  = 3'd0;
      r.ok    = 1'b0;
      pre     = 0;
      pos     = -1;
      n       = pkt.size();
      for (int i = 0; i < n && pos < 0; i++)
      begin
         if (pkt[i] == PREAMBLE_OCTET)
            pre++;
         else
            pos = i;
      end
      if (pos < 0)
         return r;  // nothing but preamble
      d     = pkt[pos];
      after = n - pos - 1;
      if (pre < MIN_PREAMBLE)
         r.kind = SMD_ERR;
      else if (d == SMD_V_CODE)
         r.kind = SMD_V;
      else if (d == SMD_R_CODE)
         r.kind = SMD_R;
      else if (d == SMD_E_CODE)
         r.kind = SMD_E;
      else
      begin
         r.kind = SMD_ERR;  // stays so unless a table matches
         for (int k = 0; k < 4; k++)
         begin
            if (d == SMD_S_CODES[k])
            begin
               r.kind  = SMD_S;
               r.frame = 2'(k);
            end
            if (d == SMD_C_CODES[k])
            begin
               r.kind  = SMD_C;
               r.frame = 2'(k);
            end
         end
      end
      if (r.kind == SMD_C && after == 0)
      begin
         r.kind  = SMD_NONE;  // header never completes without the fragment octet
         r.frame = 2'd0;
      end
      else if (r.kind == SMD_C)
      begin
         r.frag = FRAG_INVALID;
         for (int k = 0; k < 4; k++)
            if (pkt[pos + 1] == FRAG_CODES[k])
               r.frag = 3'(k);
      end
      if (after >= 4)
         r.ok = ({pkt[n - 4], pkt[n - 3], pkt[n - 2], pkt[n - 1]} ==
                 mcrc_word(pkt, pos + 1, after - 4));
      return r;
   endfunction

   function automatic bit known_delimiter(input logic [7:0] d);
      bit hit;
      hit = (d == PREAMBLE_OCTET) || (d == SMD_V_CODE) || (d == SMD_R_CODE) ||
            (d == SMD_E_CODE);
      for (int k = 0; k < 4; k++)
         hit = hit || (d == SMD_S_CODES[k]) || (d == SMD_C_CODES[k]);
      return hit;
   endfunction

   function automatic logic [7:0] invalid_frag();
      logic [7:0] d;
      do
         d = 8'(rand_below(256));
      while (d == FRAG_CODES[0] || d == FRAG_CODES[1] || d == FRAG_CODES[2] ||
             d == FRAG_CODES[3]);
      return d;
   endfunction

   // flip counts back from the last octet, -1 leaves the mPacket intact
   task automatic build_mpacket(input int npre, input logic [7:0] smd, input int nfrag,
                                input logic [7:0] frag, input int npay, input bit crc,
                                input int flip, input int tail, input int idle);
      octet_q_t    pkt;
      int          hdr_len;
      logic [31:0] w;
      logic [7:0]  d;
      pkt = {};
      repeat (npre) pkt.push_back(PREAMBLE_OCTET);
      pkt.push_back(smd);
      hdr_len = pkt.size();
      if (nfrag != 0)
         pkt.push_back(frag);
      repeat (npay) pkt.push_back(8'(rand_below(256)));
      if (crc)
      begin
         w = mcrc_word(pkt, hdr_len, pkt.size() - hdr_len);
         pkt.push_back(w[31:24]);  // msb goes out first
         pkt.push_back(w[23:16]);
         pkt.push_back(w[15:8]);
         pkt.push_back(w[7:0]);
      end
      if (flip >= 0)
         pkt[pkt.size() - 1 - flip] = pkt[pkt.size() - 1 - flip] ^ (8'd1 << rand_below(8));
      exp_q.push_back(expected_result(pkt));
      foreach (pkt[i])
      begin
         d = pkt[i];
         for (int b = 0; b < 8; b++)
            stim_q.push_back({1'b1, d[b]});
      end
      repeat (tail) stim_q.push_back({1'b1, 1'(rand_below(2))});  // partial octet
      repeat (idle) stim_q.push_back(2'b00);
   endtask

   task automatic build_all();
      logic [7:0] code;
      int         n;
      for (int f = 0; f < 4; f++)
         repeat (3)
            build_mpacket(3 + rand_below(5), SMD_S_CODES[f], 0, 8'h00, rand_below(40), 1, -1,
                          0, 1 + rand_below(4));
      for (int f = 0; f < 4; f++)
         for (int g = 0; g < 4; g++)
            build_mpacket(3 + rand_below(5), SMD_C_CODES[f], 1, FRAG_CODES[g], rand_below(30),
                          1, -1, 0, 1 + rand_below(4));
      repeat (3)
         build_mpacket(7, SMD_C_CODES[rand_below(4)], 1, invalid_frag(), 12, 1, -1, 0, 2);
      build_mpacket(7, SMD_V_CODE, 0, 8'h00, 20, 1, -1, 0, 2);
      build_mpacket(5, SMD_R_CODE, 0, 8'h00, 20, 1, -1, 0, 2);
      build_mpacket(3, SMD_E_CODE, 0, 8'h00, 30, 1, -1, 0, 2);
      repeat (3)
      begin
         do
            code = 8'(rand_below(256));
         while (known_delimiter(code));
         build_mpacket(7, code, 0, 8'h00, 10, 1, -1, 0, 2);
      end
      build_mpacket(2, SMD_S_CODES[1], 0, 8'h00, 10, 1, -1, 0, 2);  // preamble too short
      build_mpacket(2, SMD_V_CODE, 0, 8'h00, 10, 1, -1, 0, 2);
      repeat (4)
      begin
         n = 1 + rand_below(30);
         build_mpacket(7, SMD_S_CODES[2], 0, 8'h00, n, 1, 4 + rand_below(n), 0, 2);
      end
      repeat (4)
         build_mpacket(7, SMD_S_CODES[3], 0, 8'h00, 20, 1, rand_below(4), 0, 2);
      for (int k = 0; k < 4; k++)
         build_mpacket(7, SMD_S_CODES[0], 0, 8'h00, k, 0, -1, 0, 2);  // under four octets
      repeat (4)
         build_mpacket(7, SMD_S_CODES[1], 0, 8'h00, 16, 1, -1, 1 + rand_below(7), 2);
      repeat (4)
         build_mpacket(3, SMD_C_CODES[2], 1, FRAG_CODES[1], 8, 1, -1, rand_below(3), 1);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_kind(input smd_kind_t got, input smd_kind_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %0t: result_kind is %s, expected %s",
                             $time, got.name(), exp.name()));
   endtask

   task automatic check_count(input string field, input logic [2:0] got,
                              input logic [2:0] exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, field, got, exp));
   endtask

   task automatic check_flag(input string field, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, field, got, exp));
   endtask

   // outputs move on the rising edge, so they are read on the falling one
   initial
   begin : compare_results
      exp_t e;
      forever
      begin
         @(negedge rTXByteSent);
         if (result_strobe === 1'b1)
         begin
            if (exp_q.size() == 0)
               abort_run("result_strobe pulsed with no mPacket outstanding");
            else
            begin
               e = exp_q.pop_front();
               check_kind(result_kind, e.kind);
               check_count("result_frame_cnt", {1'b0, result_frame_cnt}, {1'b0, e.frame});
               check_count("result_frag_cnt", result_frag_cnt, e.frag);
               check_flag("result_mcrc_ok", result_mcrc_ok, e.ok);
               n_checked++;
            end
         end
      end
   end

   initial
   begin : watchdog
      longint limit_ns;
      wait (stim_ready);
      limit_ns = (longint'(stim_q.size()) + 8 + 40) * 10 * 2;  // twice the stimulus length
      #(limit_ns);
      abort_run("watchdog expired before all mPacket results arrived");
   end

   initial
   begin : drive
      int waited;
      reset_begin = 1'b1;
      rx_bit      = 1'b0;
      rx_dv       = 1'b0;
      build_all();
      stim_ready  = 1'b1;
      repeat (8) @(negedge rTXByteSent);
      reset_begin = 1'b0;
      repeat (3) @(negedge rTXByteSent);
      foreach (stim_q[i])
      begin
         @(negedge rTXByteSent);
         rx_dv  = stim_q[i][1];
         rx_bit = stim_q[i][0];
      end
      @(negedge rTXByteSent);
      rx_dv  = 1'b0;
      waited = 0;
      while (exp_q.size() != 0 && waited < 20)
      begin
         @(negedge rTXByteSent);
         waited++;
      end
      repeat (5) @(negedge rTXByteSent);  // room for a stray extra result
      $display("%0d mPacket results compared", n_checked);
      if (exp_q.size() == 0)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
         abort_run("some mPackets produced no result");
   end

endmodule

`default_nettype wire

//--- src/mcrc_checker.sv
//////////////////////////////
// mCRC checker
// bit-serial CRC behind a four octet delay line
// compare against the trailing four octets
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mcrc_checker import mm_rx_pkg::*;
(
   input  logic    rTXByteSent,
   input  logic    reset_begin,
   mm_octet_if.sink oct,
   mm_hdr_if.sink   hdr,
   output logic    mcrc_ok
);

   logic        armed;      // between the SMD and the next mPacket start
   logic [2:0]  oct_cnt;    // octets after the SMD, stops at four
   logic [7:0]  dly [0:3];  // dly[3] is the oldest octet
   logic [31:0] crc;
   logic        crc_match;

   // eight serial steps, data lsb first, shift towards bit 31
   function automatic logic [31:0] crc_octet(input logic [31:0] crc_in,
                                             input logic [7:0]  data);
      logic [31:0] c;
      c = crc_in;
      for (int b = 0; b < 8; b++)
      begin
         if (data[b] ^ c[31])
            c = (c << 1) ^ MCRC_POLY;
         else
            c = c << 1;
      end
      return c;
   endfunction

   // the delay line holds the received mCRC, first arrival is the msb
   assign crc_match = ({dly[3], dly[2], dly[1], dly[0]} == (crc ^ MCRC_XOR));

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         armed   <= 1'b0;
         oct_cnt <= '0;
         mcrc_ok <= 1'b0;
      end
      else
      begin
         if (oct.mpacket_start)
            armed <= 1'b0;
         else if (hdr.smd_strobe)
         begin
            armed   <= 1'b1;
            oct_cnt <= '0;
         end
         else if (armed && oct.octet_strobe && oct_cnt != 3'd4)
            oct_cnt <= oct_cnt + 3'd1;
         // under four octets the delay line is not even full, so the result is false
         if (oct.mpacket_end)
            mcrc_ok <= armed && (oct_cnt == 3'd4) && crc_match;
      end
   end

   always_ff @(posedge rTXByteSent)
   begin
      if (hdr.smd_strobe)
         crc <= MCRC_INIT;
      else if (armed && oct.octet_strobe)
      begin
         dly[0] <= oct.octet;
         dly[1] <= dly[0];
         dly[2] <= dly[1];
         dly[3] <= dly[2];
         if (oct_cnt == 3'd4)
            crc <= crc_octet(crc, dly[3]);  // only octets leaving the line are covered
      end
   end

   // the decoder must report a single SMD per mPacket or coverage restarts mid frame
   a_one_smd: assert property (@(posedge rTXByteSent) disable iff (reset_begin)
      hdr.smd_strobe |-> !armed)
      else $error("second SMD inside one mPacket");

   // an octet arriving with mpacket_end would miss the final compare
   a_no_octet_at_end: assert property (@(posedge rTXByteSent) disable iff (reset_begin)
      !(oct.octet_strobe && oct.mpacket_end))
      else $error("octet strobe coincides with mpacket end");

endmodule

`default_nettype wire

//--- src/mm_hdr_if.sv
//////////////////////////////
// decoded header bus
// SMD position, kind, frame and fragment counts
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface mm_hdr_if import mm_rx_pkg::*;;

   logic       smd_strobe;  // cycle after the octet strobe that carried the SMD
   logic       hdr_strobe;  // header complete, one octet later for SMD-C
   smd_kind_t  kind;
   logic [1:0] frame_cnt;
   logic [2:0] frag_cnt;    // FRAG_INVALID for an unknown fragment code

   // fields hold from hdr_strobe until the next mPacket starts
   modport source (output smd_strobe, output hdr_strobe,
                   output kind, output frame_cnt, output frag_cnt);

   modport sink (input smd_strobe, input hdr_strobe,
                 input kind, input frame_cnt, input frag_cnt);

endinterface

`default_nettype wire

//--- src/mm_octet_if.sv
//////////////////////////////
// octet stream bus
// octet strobe and mPacket boundaries
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface mm_octet_if;

   logic       octet_strobe;   // one cycle per assembled octet
   logic [7:0] octet;          // only meaningful while octet_strobe is high
   logic       mpacket_start;  // data valid went high
   logic       mpacket_end;    // data valid went low, never together with octet_strobe

   // the deserializer drives the bus
   modport source (output octet_strobe, output octet,
                   output mpacket_start, output mpacket_end);

   // decoder, mCRC checker and reporter all listen
   modport sink (input octet_strobe, input octet,
                 input mpacket_start, input mpacket_end);

endinterface

`default_nettype wire

//--- src/mm_rx_pkg.sv
//////////////////////////////
// mPacket receive constants
// smd_kind_t result class
// delimiter and fragment tables, preamble octet
// mCRC polynomial, seed and mask, decoder state codes
//////////////////////////////
`default_nettype none

package mm_rx_pkg;

   // one result class per mPacket, ERR covers unknown codes and short preambles
   typedef enum logic [2:0]
   {
      SMD_NONE,  // no delimiter found before the end of the mPacket
      SMD_V,     // verify
      SMD_R,     // respond
      SMD_E,     // express frame
      SMD_S,     // start of a preemptable frame
      SMD_C,     // continuation fragment
      SMD_ERR
   } smd_kind_t;

   localparam logic [7:0] PREAMBLE_OCTET = 8'h55;
   localparam int         MIN_PREAMBLE   = 3;  // preamble octets needed ahead of an SMD

   localparam logic [7:0] SMD_V_CODE = 8'h07;
   localparam logic [7:0] SMD_R_CODE = 8'h19;
   localparam logic [7:0] SMD_E_CODE = 8'hD5;  // same octet as the ordinary SFD

   // index is the frame count carried by the delimiter
   localparam logic [7:0] SMD_S_CODES [0:3] = '{8'hE6, 8'h4C, 8'h7F, 8'hB3};
   localparam logic [7:0] SMD_C_CODES [0:3] = '{8'h61, 8'h52, 8'h9E, 8'h2A};

   // fragment count encodings happen to reuse the SMD-S octets
   // but they are looked up on their own, one octet after an SMD-C
   localparam logic [7:0] FRAG_CODES [0:3] = '{8'hE6, 8'h4C, 8'h7F, 8'hB3};
   localparam logic [2:0] FRAG_INVALID     = 3'd4;

   // mCRC is the FCS CRC-32 with the low half of the result inverted
   localparam logic [31:0] MCRC_POLY = 32'h04C1_1DB7;
   localparam logic [31:0] MCRC_INIT = 32'hFFFF_FFFF;
   localparam logic [31:0] MCRC_XOR  = 32'h0000_FFFF;

   // smd_decoder states
   localparam logic [1:0] ST_PREAMBLE = 2'd0;  // counting 0x55 octets
   localparam logic [1:0] ST_FRAG     = 2'd1;  // SMD-C seen, fragment count octet next
   localparam logic [1:0] ST_DONE     = 2'd2;  // header complete, rest is payload

endpackage

`default_nettype wire

//--- src/mm_rx_top.sv
//////////////////////////////
// MAC merge receive top
// deserializer, SMD decoder, mCRC checker, reporter
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_rx_top import mm_rx_pkg::*;
(
   input  logic       rTXByteSent,
   input  logic       reset_begin,
   input  logic       rx_bit,            // serial data, lsb of each octet first
   input  logic       rx_dv,             // qualifies rx_bit, low between mPackets
   output logic       result_strobe,     // one pulse per mPacket
   output smd_kind_t  result_kind,
   output logic [1:0] result_frame_cnt,
   output logic [2:0] result_frag_cnt,
   output logic       result_mcrc_ok
);

   mm_octet_if oct_bus ();
   mm_hdr_if   hdr_bus ();
   logic       mcrc_ok;  // verdict of the last finished mPacket

   rx_deserializer i_deser (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .rx_bit      (rx_bit),
      .rx_dv       (rx_dv),
      .oct         (oct_bus.source)
   );

   smd_decoder i_smd (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .oct         (oct_bus.sink),
      .hdr         (hdr_bus.source)
   );

   mcrc_checker i_mcrc (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .oct         (oct_bus.sink),
      .hdr         (hdr_bus.sink),
      .mcrc_ok     (mcrc_ok)
   );

   rx_result_reporter i_report (
      .rTXByteSent      (rTXByteSent),
      .reset_begin      (reset_begin),
      .oct              (oct_bus.sink),
      .hdr              (hdr_bus.sink),
      .mcrc_ok          (mcrc_ok),
      .result_strobe    (result_strobe),
      .result_kind      (result_kind),
      .result_frame_cnt (result_frame_cnt),
      .result_frag_cnt  (result_frag_cnt),
      .result_mcrc_ok   (result_mcrc_ok)
   );

endmodule

`default_nettype wire

//--- src/rx_deserializer.sv
//////////////////////////////
// serial to octet converter
// LSB first, start/end strobes from rx_dv
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_deserializer
(
   input  logic      rTXByteSent,
   input  logic      reset_begin,
   input  logic      rx_bit,
   input  logic      rx_dv,
   mm_octet_if.source oct
);

   logic       bit_q;    // rx_bit sampled at the pin
   logic       dv_q;     // rx_dv sampled at the pin
   logic       dv_qq;    // previous dv_q, for edge detection
   logic [2:0] bit_cnt;  // position of bit_q inside the current octet
   logic [6:0] shift;    // first seven bits, oldest ends up in bit 0

   // control side, all strobes come out one cycle after the sampling edge
   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         dv_q              <= 1'b0;
         dv_qq             <= 1'b0;
         bit_cnt           <= '0;
         oct.octet_strobe  <= 1'b0;
         oct.mpacket_start <= 1'b0;
         oct.mpacket_end   <= 1'b0;
      end
      else
      begin
         dv_q              <= rx_dv;
         dv_qq             <= dv_q;
         oct.mpacket_start <= dv_q & ~dv_qq;
         oct.mpacket_end   <= ~dv_q & dv_qq;
         oct.octet_strobe  <= dv_q && (bit_cnt == 3'd7);
         bit_cnt           <= dv_q ? bit_cnt + 3'd1 : 3'd0;  // a partial octet is dropped here
      end
   end

   // data side
   always_ff @(posedge rTXByteSent)
   begin
      bit_q <= rx_bit;
      if (dv_q)
      begin
         shift <= {bit_q, shift[6:1]};
         if (bit_cnt == 3'd7)
            oct.octet <= {bit_q, shift};  // eighth bit lands in the msb
      end
   end

endmodule

`default_nettype wire

//--- src/rx_result_reporter.sv
//////////////////////////////
// result reporter
// header latch and one result per mPacket
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_result_reporter import mm_rx_pkg::*;
(
   input  logic       rTXByteSent,
   input  logic       reset_begin,
   mm_octet_if.sink    oct,
   mm_hdr_if.sink      hdr,
   input  logic       mcrc_ok,
   output logic       result_strobe,
   output smd_kind_t  result_kind,
   output logic [1:0] result_frame_cnt,
   output logic [2:0] result_frag_cnt,
   output logic       result_mcrc_ok
);

   smd_kind_t  kind_q;   // SMD_NONE until a header arrives
   logic [1:0] frame_q;
   logic [2:0] frag_q;
   smd_kind_t  cur_kind;
   logic [1:0] cur_frame;

   // a header can complete in the very cycle of mpacket_end, so take it straight from the bus
   assign cur_kind  = hdr.hdr_strobe ? hdr.kind : kind_q;
   assign cur_frame = hdr.hdr_strobe ? hdr.frame_cnt : frame_q;

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin || oct.mpacket_start)
      begin
         kind_q  <= SMD_NONE;
         frame_q <= '0;
         frag_q  <= '0;
      end
      else if (hdr.hdr_strobe)
      begin
         kind_q  <= hdr.kind;
         frame_q <= hdr.frame_cnt;
         frag_q  <= hdr.frag_cnt;
      end
   end

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         result_strobe    <= 1'b0;
         result_kind      <= SMD_NONE;
         result_frame_cnt <= '0;
         result_frag_cnt  <= '0;
      end
      else
      begin
         result_strobe <= oct.mpacket_end;
         if (oct.mpacket_end)
         begin
            result_kind      <= cur_kind;
            result_frame_cnt <= cur_frame;
            // fragment count only means something for a continuation
            result_frag_cnt  <= (cur_kind == SMD_C) ? (hdr.hdr_strobe ? hdr.frag_cnt : frag_q)
                                                    : 3'd0;
         end
      end
   end

   assign result_mcrc_ok = mcrc_ok;  // checker loads it on the same edge as result_strobe

endmodule

`default_nettype wire

//--- src/smd_decoder.sv
//////////////////////////////
// SMD decoder
// preamble count, delimiter classification
// fragment count lookup after SMD-C
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module smd_decoder import mm_rx_pkg::*;
(
   input  logic      rTXByteSent,
   input  logic      reset_begin,
   mm_octet_if.sink   oct,
   mm_hdr_if.source   hdr
);

   logic [1:0] state;
   logic [1:0] pre_cnt;    // preamble octets seen, saturates at MIN_PREAMBLE
   logic       smd_seen;   // first non-preamble octet of the mPacket
   logic       short_pre;  // not enough preamble ahead of the SMD
   smd_kind_t  smd_kind;   // class of the current octet taken as a delimiter
   logic [1:0] smd_frame;
   logic [2:0] frag_dec;

   assign smd_seen  = oct.octet_strobe && (state == ST_PREAMBLE) &&
                      (oct.octet != PREAMBLE_OCTET);
   assign short_pre = pre_cnt < MIN_PREAMBLE;

   // delimiter lookup, anything not in the tables is an error
   always_comb
   begin
      smd_kind  = SMD_ERR;
      smd_frame = 2'd0;
      if (oct.octet == SMD_V_CODE)
         smd_kind = SMD_V;
      else if (oct.octet == SMD_R_CODE)
         smd_kind = SMD_R;
      else if (oct.octet == SMD_E_CODE)
         smd_kind = SMD_E;
      for (int i = 0; i < 4; i++)
      begin
         if (oct.octet == SMD_S_CODES[i])
         begin
            smd_kind  = SMD_S;
            smd_frame = 2'(i);
         end
         if (oct.octet == SMD_C_CODES[i])
         begin
            smd_kind  = SMD_C;
            smd_frame = 2'(i);
         end
      end
   end

   // fragment count table, unknown codes report 4
   always_comb
   begin
      frag_dec = FRAG_INVALID;
      for (int i = 0; i < 4; i++)
      begin
         if (oct.octet == FRAG_CODES[i])
            frag_dec = 3'(i);
      end
   end

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         state          <= ST_PREAMBLE;
         pre_cnt        <= '0;
         hdr.smd_strobe <= 1'b0;
         hdr.hdr_strobe <= 1'b0;
      end
      else
      begin
         hdr.smd_strobe <= smd_seen;
         hdr.hdr_strobe <= 1'b0;
         if (oct.mpacket_start)
         begin
            state   <= ST_PREAMBLE;
            pre_cnt <= '0;
         end
         else if (smd_seen)
         begin
            // SMD-C waits one more octet for its fragment count
            hdr.hdr_strobe <= short_pre || (smd_kind != SMD_C);
            state          <= (!short_pre && smd_kind == SMD_C) ? ST_FRAG : ST_DONE;
         end
         else if (oct.octet_strobe && state == ST_PREAMBLE && pre_cnt != 2'(MIN_PREAMBLE))
            pre_cnt <= pre_cnt + 2'd1;
         else if (oct.octet_strobe && state == ST_FRAG)
         begin
            hdr.hdr_strobe <= 1'b1;
            state          <= ST_DONE;
         end
      end
   end

   // header fields, held until the next delimiter
   always_ff @(posedge rTXByteSent)
   begin
      if (smd_seen)
      begin
         hdr.kind      <= short_pre ? SMD_ERR : smd_kind;
         hdr.frame_cnt <= short_pre ? 2'd0 : smd_frame;
         hdr.frag_cnt  <= 3'd0;
      end
      else if (oct.octet_strobe && state == ST_FRAG)
         hdr.frag_cnt <= frag_dec;
   end

   // the restart branch wins over an octet that arrives with mpacket_start
   a_no_octet_at_start: assert property (@(posedge rTXByteSent) disable iff (reset_begin)
      !(oct.octet_strobe && oct.mpacket_start))
      else $error("octet strobe coincides with mpacket start");

endmodule

`default_nettype wire
